//--- verilog/backend_pkg.sv
`default_nettype none

package backend_pkg;

	parameter int XLEN      = 32;
	parameter int ARN_W     = 4;
	parameter int PRN_W     = 5;
	parameter int ROB_TAG_W = 3;
	parameter int IMM_W     = 16;

	// unknown encodings are treated as op_illegal
	typedef enum logic [3:0] {
		op_add     = 4'h0,
		op_sub     = 4'h1,
		op_and     = 4'h2,
		op_or      = 4'h3,
		op_xor     = 4'h4,
		op_addi    = 4'h5,
		op_beq     = 4'h6,
		op_bne     = 4'h7,
		op_illegal = 4'hf
	} opcode_e;

	typedef enum logic [1:0] {
		st_run     = 2'd0,
		st_flush   = 2'd1,
		st_recover = 2'd2,
		st_halted  = 2'd3
	} ctrl_state_e;

	typedef struct packed {
		logic             valid;
		logic [XLEN-1:0]  pc;
		opcode_e          opcode;
		logic [ARN_W-1:0] dest_arn;
		logic [ARN_W-1:0] src1_arn;
		logic [ARN_W-1:0] src2_arn;
		logic [IMM_W-1:0] imm;
	} fetch_pkt_t;

	typedef struct packed {
		logic                 valid;
		logic [XLEN-1:0]      pc;
		opcode_e              opcode;
		logic [IMM_W-1:0]     imm;
		logic [PRN_W-1:0]     src1_prn;
		logic [PRN_W-1:0]     src2_prn;
		logic                 src1_rdy;
		logic                 src2_rdy;
		logic [PRN_W-1:0]     dest_prn;
		logic                 has_dest;
		logic [ROB_TAG_W-1:0] rob_tag;
	} iq_entry_t;

	typedef struct packed {
		logic                 valid;
		logic [ROB_TAG_W-1:0] rob_tag;
		logic [PRN_W-1:0]     dest_prn;
		logic                 has_dest;
		logic [XLEN-1:0]      result;
		logic                 branch_taken;
		logic [XLEN-1:0]      redirect_pc;
	} wb_pkt_t;

	// commit trace, dest_arn is zero when nothing is written
	typedef struct packed {
		logic             valid;
		logic [XLEN-1:0]  pc;
		logic [ARN_W-1:0] dest_arn;
		logic [XLEN-1:0]  result;
		logic             is_branch;
		logic             branch_taken;
		logic             exception;
	} retire_pkt_t;

endpackage

`default_nettype wire

//--- verilog/backend_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module backend_ctrl import backend_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic misp,
	input  logic exception,
	output logic dispatch_en,
	output logic flush,
	output logic recover
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			st_run: begin
				if (exception)
					state_nxt = st_halted;
				else if (misp)
					state_nxt = st_flush;
			end
			// recovery trails the flush so the last arch map write lands first
			st_flush:   state_nxt = st_recover;
			st_recover: state_nxt = st_run;
			default:    state_nxt = st_halted;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_run;
		else
			state <= state_nxt;
	end

	// no dispatch while the retire pulse is still up
	assign dispatch_en = (state == st_run) && !misp && !exception;
	// halted keeps the queues empty
	assign flush       = (state == st_flush) || (state == st_halted);
	assign recover     = (state == st_recover);

endmodule

`default_nettype wire

//--- verilog/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit import backend_pkg::*; #(
	parameter int PRF_DEPTH = 32
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fetch_pkt_t           fetch_pkt,
	input  logic                 dispatch_en,
	input  logic                 iq_full,
	input  logic                 rob_full,
	input  wb_pkt_t              wb,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	input  retire_pkt_t          retire,
	input  logic [PRN_W-1:0]     commit_prn,
	input  logic [PRN_W-1:0]     commit_prev_prn,
	input  logic                 recover,
	output logic                 fetch_ready,
	output iq_entry_t            renamed,
	output logic [PRN_W-1:0]     renamed_prev_prn
);

	localparam int NUM_ARCH = 2 ** ARN_W;

	logic [PRN_W-1:0]     spec_map [NUM_ARCH];
	logic [PRN_W-1:0]     arch_map [NUM_ARCH];
	logic [PRF_DEPTH-1:0] free_vec;
	logic [PRF_DEPTH-1:0] busy_vec;
	logic [PRF_DEPTH-1:0] arch_used;
	logic                 is_alu;
	logic                 legal;
	logic                 needs_dest;
	logic                 free_any;
	logic [PRN_W-1:0]     free_prn;
	logic                 accept;

	// ready unless busy, or written back this very cycle
	function automatic logic src_ready(input logic [PRN_W-1:0] prn);
		return !busy_vec[prn] || (wb.valid && wb.has_dest && wb.dest_prn == prn);
	endfunction

	always_comb begin
		case (fetch_pkt.opcode)
			op_add, op_sub, op_and, op_or, op_xor, op_addi: is_alu = 1'b1;
			default: is_alu = 1'b0;
		endcase
		legal      = is_alu || fetch_pkt.opcode inside {op_beq, op_bne};
		needs_dest = fetch_pkt.valid && is_alu && fetch_pkt.dest_arn != '0;
	end

	// lowest free physical register
	always_comb begin
		free_any = 1'b0;
		free_prn = '0;
		for (int p = PRF_DEPTH - 1; p >= 0; p--) begin
			if (free_vec[p]) begin
				free_any = 1'b1;
				free_prn = PRN_W'(p);
			end
		end
	end

	assign fetch_ready = dispatch_en && !iq_full && !rob_full && !(needs_dest && !free_any);
	assign accept      = fetch_pkt.valid && fetch_ready;
	assign renamed_prev_prn = spec_map[fetch_pkt.dest_arn];

	always_comb begin
		renamed          = '0;
		renamed.valid    = accept;
		renamed.pc       = fetch_pkt.pc;
		renamed.opcode   = legal ? fetch_pkt.opcode : op_illegal;
		renamed.imm      = fetch_pkt.imm;
		renamed.src1_prn = spec_map[fetch_pkt.src1_arn];
		renamed.src2_prn = spec_map[fetch_pkt.src2_arn];
		renamed.src1_rdy = src_ready(renamed.src1_prn);
		renamed.src2_rdy = src_ready(renamed.src2_prn);
		renamed.dest_prn = needs_dest ? free_prn : '0;
		renamed.has_dest = needs_dest;
		renamed.rob_tag  = rob_tag;
	end

	// everything not held by the arch map is free after recovery
	always_comb begin
		arch_used = '0;
		for (int a = 0; a < NUM_ARCH; a++)
			arch_used[arch_map[a]] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int a = 0; a < NUM_ARCH; a++) begin
				spec_map[a] <= PRN_W'(a);
				arch_map[a] <= PRN_W'(a);
			end
			for (int p = 0; p < PRF_DEPTH; p++) begin
				free_vec[p] <= (p >= NUM_ARCH);
			end
			busy_vec <= '0;
		end else if (recover) begin
			spec_map <= arch_map;
			free_vec <= ~arch_used;
			busy_vec <= '0;
		end else begin
			if (retire.valid && retire.dest_arn != '0) begin
				arch_map[retire.dest_arn] <= commit_prn;
				free_vec[commit_prev_prn] <= 1'b1;
			end
			if (wb.valid && wb.has_dest)
				busy_vec[wb.dest_prn] <= 1'b0;
			if (accept && needs_dest) begin
				spec_map[fetch_pkt.dest_arn] <= free_prn;
				free_vec[free_prn]           <= 1'b0;
				busy_vec[free_prn]           <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue import backend_pkg::*; #(
	parameter int IQ_DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	input  iq_entry_t enq,
	input  wb_pkt_t   wb,
	output logic      full,
	output iq_entry_t issue
);

	localparam int IDX_W = $clog2(IQ_DEPTH);

	// collapsing queue, index 0 holds the oldest entry
	iq_entry_t           q     [IQ_DEPTH];
	iq_entry_t           q_nxt [IQ_DEPTH];
	iq_entry_t           woken [IQ_DEPTH];
	logic [IQ_DEPTH-1:0] can_issue;
	logic                sel_valid;
	logic [IDX_W-1:0]    sel_idx;
	logic                enq_ok;
	logic                placed;

	assign full   = q[IQ_DEPTH-1].valid;
	// illegal ops complete in the ROB and never issue
	assign enq_ok = enq.valid && enq.opcode != op_illegal;

	always_comb begin
		for (int i = 0; i < IQ_DEPTH; i++) begin
			woken[i]     = q[i];
			can_issue[i] = q[i].valid && q[i].src1_rdy && q[i].src2_rdy;
			if (wb.valid && wb.has_dest) begin
				if (q[i].src1_prn == wb.dest_prn)
					woken[i].src1_rdy = 1'b1;
				if (q[i].src2_prn == wb.dest_prn)
					woken[i].src2_rdy = 1'b1;
			end
		end
	end

	// oldest ready wins
	always_comb begin
		sel_valid = 1'b0;
		sel_idx   = '0;
		for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
			if (can_issue[i]) begin
				sel_valid = 1'b1;
				sel_idx   = IDX_W'(i);
			end
		end
		issue = sel_valid ? q[sel_idx] : '0;
	end

	always_comb begin
		for (int i = 0; i < IQ_DEPTH - 1; i++)
			q_nxt[i] = (sel_valid && i >= sel_idx) ? woken[i + 1] : woken[i];
		q_nxt[IQ_DEPTH-1] = sel_valid ? '0 : woken[IQ_DEPTH-1];
		placed = 1'b0;
		for (int i = 0; i < IQ_DEPTH; i++) begin
			if (enq_ok && !placed && !q_nxt[i].valid) begin
				q_nxt[i] = enq;
				placed   = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < IQ_DEPTH; i++)
				q[i] <= '0;
		end else if (flush) begin
			for (int i = 0; i < IQ_DEPTH; i++)
				q[i].valid <= 1'b0;
		end else begin
			q <= q_nxt;
		end
	end

endmodule

`default_nettype wire

//--- verilog/prf.sv
`timescale 1ns/1ps
`default_nettype none

module prf import backend_pkg::*; #(
	parameter int PRF_DEPTH = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [PRN_W-1:0] rd_a_addr,
	input  logic [PRN_W-1:0] rd_b_addr,
	output logic [XLEN-1:0]  rd_a_data,
	output logic [XLEN-1:0]  rd_b_data,
	input  wb_pkt_t          wr
);

	logic [XLEN-1:0] regs [PRF_DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int p = 0; p < PRF_DEPTH; p++)
				regs[p] <= '0;
		end else if (wr.valid && wr.has_dest) begin
			regs[wr.dest_prn] <= wr.result;
		end
	end

	// no bypass, a write shows up the cycle after
	assign rd_a_data = regs[rd_a_addr];
	assign rd_b_data = regs[rd_b_addr];

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import backend_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             flush,
	input  iq_entry_t        issue,
	output logic [PRN_W-1:0] rd_a_addr,
	output logic [PRN_W-1:0] rd_b_addr,
	input  logic [XLEN-1:0]  rd_a_data,
	input  logic [XLEN-1:0]  rd_b_data,
	output wb_pkt_t          wb
);

	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] result;
	logic            taken;

	assign rd_a_addr = issue.src1_prn;
	assign rd_b_addr = issue.src2_prn;
	assign imm_ext   = {{(XLEN - IMM_W){issue.imm[IMM_W-1]}}, issue.imm};
	assign op_b      = (issue.opcode == op_addi) ? imm_ext : rd_b_data;

	always_comb begin
		result = '0;
		taken  = 1'b0;
		case (issue.opcode)
			op_add, op_addi: result = rd_a_data + op_b;
			op_sub:          result = rd_a_data - op_b;
			op_and:          result = rd_a_data & op_b;
			op_or:           result = rd_a_data | op_b;
			op_xor:          result = rd_a_data ^ op_b;
			// predicted not-taken, so taken means mispredict
			op_beq:          taken  = (rd_a_data == rd_b_data);
			op_bne:          taken  = (rd_a_data != rd_b_data);
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.valid        <= issue.valid && !flush;
			wb.rob_tag      <= issue.rob_tag;
			wb.dest_prn     <= issue.dest_prn;
			wb.has_dest     <= issue.has_dest;
			wb.result       <= result;
			wb.branch_taken <= taken;
			wb.redirect_pc  <= issue.pc + imm_ext;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob import backend_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  iq_entry_t            alloc,
	input  logic [PRN_W-1:0]     alloc_prev_prn,
	input  logic [ARN_W-1:0]     alloc_dest_arn,
	input  logic                 alloc_illegal,
	output logic [ROB_TAG_W-1:0] alloc_tag,
	output logic                 full,
	input  wb_pkt_t              wb,
	output retire_pkt_t          retire,
	output logic [PRN_W-1:0]     commit_prn,
	output logic [PRN_W-1:0]     commit_prev_prn,
	output logic                 retire_br_misp,
	output logic [XLEN-1:0]      retire_redirect_pc,
	output logic                 retire_exception
);

	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	typedef struct packed {
		logic [XLEN-1:0]  pc;
		logic [ARN_W-1:0] dest_arn;
		logic [PRN_W-1:0] dest_prn;
		logic [PRN_W-1:0] prev_prn;
		logic             is_branch;
		logic             exception;
	} rob_info_t;

	rob_info_t            info       [ROB_DEPTH];
	logic [XLEN-1:0]      result_q   [ROB_DEPTH];
	logic [XLEN-1:0]      redirect_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] taken_q;
	logic [ROB_DEPTH-1:0] valid_q;
	logic [ROB_DEPTH-1:0] done_q;
	logic [IDX_W-1:0]     head;
	logic [IDX_W-1:0]     tail;
	logic [CNT_W-1:0]     count;
	logic                 do_retire;

	assign alloc_tag = ROB_TAG_W'(tail);
	assign full      = (count == CNT_W'(ROB_DEPTH));

	assign retire_exception = retire.valid && retire.exception;
	// nothing younger retires behind a redirect or an exception
	assign do_retire = valid_q[head] && done_q[head] && !retire_br_misp && !retire_exception;

	////////////////////////////////////////////////////////////////////
	// entry payload

	always_ff @(posedge clk) begin
		if (alloc.valid) begin
			info[tail].pc        <= alloc.pc;
			info[tail].dest_arn  <= alloc.has_dest ? alloc_dest_arn : '0;
			info[tail].dest_prn  <= alloc.dest_prn;
			info[tail].prev_prn  <= alloc_prev_prn;
			info[tail].is_branch <= alloc.opcode inside {op_beq, op_bne};
			info[tail].exception <= alloc_illegal;
			result_q[tail]       <= '0;
			taken_q[tail]        <= 1'b0;
		end
		if (wb.valid) begin
			result_q[wb.rob_tag]   <= wb.result;
			taken_q[wb.rob_tag]    <= wb.branch_taken;
			redirect_q[wb.rob_tag] <= wb.redirect_pc;
		end
	end

	////////////////////////////////////////////////////////////////////
	// pointers, completion and retire register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q            <= '0;
			done_q             <= '0;
			head               <= '0;
			tail               <= '0;
			count              <= '0;
			retire             <= '0;
			commit_prn         <= '0;
			commit_prev_prn    <= '0;
			retire_redirect_pc <= '0;
			retire_br_misp     <= 1'b0;
		end else if (flush) begin
			valid_q        <= '0;
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			retire.valid   <= 1'b0;
			retire_br_misp <= 1'b0;
		end else begin
			if (alloc.valid) begin
				valid_q[tail] <= 1'b1;
				// illegal ops are born complete
				done_q[tail]  <= alloc_illegal;
				tail          <= tail + 1'b1;
			end
			if (wb.valid)
				done_q[wb.rob_tag] <= 1'b1;
			if (do_retire) begin
				valid_q[head]       <= 1'b0;
				head                <= head + 1'b1;
				retire.pc           <= info[head].pc;
				retire.dest_arn     <= info[head].dest_arn;
				retire.result       <= result_q[head];
				retire.is_branch    <= info[head].is_branch;
				retire.branch_taken <= taken_q[head];
				retire.exception    <= info[head].exception;
				commit_prn          <= info[head].dest_prn;
				commit_prev_prn     <= info[head].prev_prn;
				retire_redirect_pc  <= redirect_q[head];
			end
			retire.valid   <= do_retire;
			// taken branch at the head redirects
			retire_br_misp <= do_retire && info[head].is_branch && taken_q[head];
			count          <= count + CNT_W'(alloc.valid) - CNT_W'(do_retire);
		end
	end

endmodule

`default_nettype wire

//--- verilog/backend.sv
`timescale 1ns/1ps
`default_nettype none

module backend import backend_pkg::*; #(
	parameter int ROB_DEPTH = 8,
	parameter int IQ_DEPTH  = 4,
	parameter int PRF_DEPTH = 32
) (
	input  logic            clk,
	input  logic            rst_n,
	input  fetch_pkt_t      fetch_pkt,
	output logic            fetch_ready,
	output retire_pkt_t     retire,
	output logic            retire_br_misp,
	output logic [XLEN-1:0] retire_redirect_pc,
	output logic            retire_exception
);

	logic                 dispatch_en;
	logic                 flush;
	logic                 recover;
	iq_entry_t            renamed;
	logic [PRN_W-1:0]     renamed_prev_prn;
	logic [ROB_TAG_W-1:0] rob_tag;
	logic                 iq_full;
	logic                 rob_full;
	logic                 alloc_illegal;
	iq_entry_t            issue;
	wb_pkt_t              wb;
	logic [PRN_W-1:0]     rd_a_addr;
	logic [PRN_W-1:0]     rd_b_addr;
	logic [XLEN-1:0]      rd_a_data;
	logic [XLEN-1:0]      rd_b_data;
	logic [PRN_W-1:0]     commit_prn;
	logic [PRN_W-1:0]     commit_prev_prn;

	assign alloc_illegal = (renamed.opcode == op_illegal);

	////////////////////////////////////////////////////////////////////
	// control and rename

	backend_ctrl i_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.misp        (retire_br_misp),
		.exception   (retire_exception),
		.dispatch_en (dispatch_en),
		.flush       (flush),
		.recover     (recover)
	);

	rename_unit #(.PRF_DEPTH(PRF_DEPTH)) i_rename (
		.clk              (clk),
		.rst_n            (rst_n),
		.fetch_pkt        (fetch_pkt),
		.dispatch_en      (dispatch_en),
		.iq_full          (iq_full),
		.rob_full         (rob_full),
		.wb               (wb),
		.rob_tag          (rob_tag),
		.retire           (retire),
		.commit_prn       (commit_prn),
		.commit_prev_prn  (commit_prev_prn),
		.recover          (recover),
		.fetch_ready      (fetch_ready),
		.renamed          (renamed),
		.renamed_prev_prn (renamed_prev_prn)
	);

	////////////////////////////////////////////////////////////////////
	// issue, execute and retire

	issue_queue #(.IQ_DEPTH(IQ_DEPTH)) i_iq (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (flush),
		.enq   (renamed),
		.wb    (wb),
		.full  (iq_full),
		.issue (issue)
	);

	prf #(.PRF_DEPTH(PRF_DEPTH)) i_prf (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_a_addr (rd_a_addr),
		.rd_b_addr (rd_b_addr),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.wr        (wb)
	);

	exec_unit i_exec (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.issue     (issue),
		.rd_a_addr (rd_a_addr),
		.rd_b_addr (rd_b_addr),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.wb        (wb)
	);

	rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
		.clk                (clk),
		.rst_n              (rst_n),
		.flush              (flush),
		.alloc              (renamed),
		.alloc_prev_prn     (renamed_prev_prn),
		.alloc_dest_arn     (fetch_pkt.dest_arn),
		.alloc_illegal      (alloc_illegal),
		.alloc_tag          (rob_tag),
		.full               (rob_full),
		.wb                 (wb),
		.retire             (retire),
		.commit_prn         (commit_prn),
		.commit_prev_prn    (commit_prev_prn),
		.retire_br_misp     (retire_br_misp),
		.retire_redirect_pc (retire_redirect_pc),
		.retire_exception   (retire_exception)
	);

endmodule

`default_nettype wire

//--- sim/backend_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module backend_assertions import backend_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic        fetch_ready,
	input retire_pkt_t retire,
	input logic        retire_br_misp,
	input logic        retire_exception
);

	int   fail_count = 0;
	logic halted;

	// set by the first exception retire, cleared only by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (retire_exception)
			halted <= 1'b1;
	end

	no_fetch_after_misp: assert property (@(posedge clk) disable iff (!rst_n)
		retire_br_misp |=> !fetch_ready)
		else begin
			$error("fetch_ready high in the cycle after a mispredict");
			fail_count++;
		end

	misp_is_branch_retire: assert property (@(posedge clk) disable iff (!rst_n)
		retire_br_misp |-> retire.valid && retire.is_branch)
		else begin
			$error("mispredict pulse without a retiring branch");
			fail_count++;
		end

	no_retire_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !retire.valid)
		else begin
			$error("instruction retired after an exception");
			fail_count++;
		end

endmodule

bind backend backend_assertions i_backend_assertions (
	.clk              (clk),
	.rst_n            (rst_n),
	.fetch_ready      (fetch_ready),
	.retire           (retire),
	.retire_br_misp   (retire_br_misp),
	.retire_exception (retire_exception)
);

`default_nettype wire

//--- sim/tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend import backend_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	// six tests of about 40 instructions at up to 12 cycles each plus margin
	localparam int MAX_CYCLES = 4000;

	typedef struct packed {
		retire_pkt_t     r;
		logic [XLEN-1:0] redirect;
	} expect_t;

	logic            clk;
	logic            rst_n;
	fetch_pkt_t      fetch_pkt;
	logic            fetch_ready;
	retire_pkt_t     retire;
	logic            retire_br_misp;
	logic [XLEN-1:0] retire_redirect_pc;
	logic            retire_exception;

	// architectural reference state
	logic [XLEN-1:0] arch_regs [2 ** ARN_W];
	expect_t         exp_q [$];
	logic            squashing;
	logic            exc_seen;
	logic [XLEN-1:0] pc_next;
	int              errors;
	int              checks;
	int              stalls;
	int              cycles;

	backend #(.ROB_DEPTH(8), .IQ_DEPTH(4), .PRF_DEPTH(32)) i_backend (
		.clk                (clk),
		.rst_n              (rst_n),
		.fetch_pkt          (fetch_pkt),
		.fetch_ready        (fetch_ready),
		.retire             (retire),
		.retire_br_misp     (retire_br_misp),
		.retire_redirect_pc (retire_redirect_pc),
		.retire_exception   (retire_exception)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// retire monitor on the falling edge

	always @(negedge clk) begin
		if (rst_n && retire.valid)
			check_retire();
		if (rst_n && retire_br_misp)
			squashing = 1'b0;
		if (rst_n && retire_exception)
			exc_seen = 1'b1;
	end

	task automatic check_retire();
		expect_t e;
		checks++;
		assert (exp_q.size() != 0) else begin
			$display("ERROR: instruction at pc %h retired but none was expected", retire.pc);
			errors++;
		end
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			assert (retire.pc == e.r.pc && retire.dest_arn == e.r.dest_arn) else begin
				$display("FAIL %0t: retired pc %h rd %0d, expected pc %h rd %0d", $time,
					retire.pc, retire.dest_arn, e.r.pc, e.r.dest_arn);
				errors++;
			end
			assert (e.r.is_branch || e.r.exception || retire.result == e.r.result) else begin
				$display("FAIL %0t: pc %h result %h, expected %h", $time,
					retire.pc, retire.result, e.r.result);
				errors++;
			end
			assert (retire.is_branch == e.r.is_branch && retire.branch_taken == e.r.branch_taken
				&& retire_br_misp == e.r.branch_taken) else begin
				$display("FAIL %0t: pc %h branch %b taken %b misp %b, expected taken %b", $time,
					retire.pc, retire.is_branch, retire.branch_taken, retire_br_misp,
					e.r.branch_taken);
				errors++;
			end
			assert (!e.r.branch_taken || retire_redirect_pc == e.redirect) else begin
				$display("FAIL %0t: pc %h redirect %h, expected %h", $time,
					retire.pc, retire_redirect_pc, e.redirect);
				errors++;
			end
			assert (retire.exception == e.r.exception && retire_exception == e.r.exception)
				else begin
				$display("FAIL %0t: pc %h exception %b pulse %b, expected %b", $time,
					retire.pc, retire.exception, retire_exception, e.r.exception);
				errors++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model in program order

	task automatic model_exec(input fetch_pkt_t p);
		expect_t         e;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm_ext;
		logic [XLEN-1:0] res;
		logic            alu;
		// wrong path behind a taken branch or an illegal op
		if (squashing)
			return;
		a         = arch_regs[p.src1_arn];
		b         = arch_regs[p.src2_arn];
		imm_ext   = {{(XLEN - IMM_W){p.imm[IMM_W-1]}}, p.imm};
		e         = '0;
		e.r.valid = 1'b1;
		e.r.pc    = p.pc;
		res       = '0;
		alu       = 1'b1;
		case (p.opcode)
			op_add:  res = a + b;
			op_sub:  res = a - b;
			op_and:  res = a & b;
			op_or:   res = a | b;
			op_xor:  res = a ^ b;
			op_addi: res = a + imm_ext;
			op_beq, op_bne: begin
				alu              = 1'b0;
				e.r.is_branch    = 1'b1;
				e.r.branch_taken = (p.opcode == op_beq) ? (a == b) : (a != b);
				e.redirect       = p.pc + imm_ext;
				squashing        = e.r.branch_taken;
			end
			default: begin
				alu           = 1'b0;
				e.r.exception = 1'b1;
				squashing     = 1'b1;
			end
		endcase
		if (alu) begin
			e.r.dest_arn = p.dest_arn;
			e.r.result   = res;
			if (p.dest_arn != '0)
				arch_regs[p.dest_arn] = res;
		end
		exp_q.push_back(e);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	function automatic logic [IMM_W-1:0] rand_imm();
		return IMM_W'($urandom);
	endfunction

	// holds the packet until fetch_ready takes it
	task automatic send_op(input opcode_e op, input int rd, input int rs1, input int rs2,
		input logic [IMM_W-1:0] imm);
		fetch_pkt_t p;
		logic       accepted;
		p          = '0;
		p.valid    = 1'b1;
		p.pc       = pc_next;
		p.opcode   = op;
		p.dest_arn = ARN_W'(rd);
		p.src1_arn = ARN_W'(rs1);
		p.src2_arn = ARN_W'(rs2);
		p.imm      = imm;
		pc_next    = pc_next + 4;
		accepted   = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			fetch_pkt = p;
			#1;
			if (fetch_ready) begin
				accepted = 1'b1;
				model_exec(p);
			end else begin
				stalls++;
			end
		end
	endtask

	task automatic drive_idle();
		@(negedge clk);
		fetch_pkt = '0;
	endtask

	task automatic drain_retires();
		drive_idle();
		while (exp_q.size() != 0)
			@(negedge clk);
		// window for stray retires
		repeat (8) @(negedge clk);
	endtask

	task automatic wait_flush_done();
		drive_idle();
		while (squashing)
			@(negedge clk);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n     = 1'b0;
		fetch_pkt = '0;
		for (int i = 0; i < 2 ** ARN_W; i++)
			arch_regs[i] = '0;
		exp_q.delete();
		squashing = 1'b0;
		exc_seen  = 1'b0;
		pc_next   = 32'h0000_1000;
		stalls    = 0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		#1;
		checks++;
		assert (fetch_ready && !retire.valid && !retire_br_misp && !retire_exception) else begin
			$display("FAIL %0t: outputs not idle after reset", $time);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s: %0d errors", name, errors - err_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic independent_ops();
		int e0;
		e0 = errors;
		apply_reset();
		send_op(op_addi, 1, 0, 0, rand_imm());
		send_op(op_addi, 2, 0, 0, rand_imm());
		send_op(op_addi, 3, 0, 0, rand_imm());
		send_op(op_addi, 4, 0, 0, 16'h8001);
		// writes to r0 are dropped
		send_op(op_addi, 0, 0, 0, 16'h0055);
		send_op(op_add, 0, 1, 2, 0);
		send_op(op_or, 5, 0, 0, 0);
		send_op(op_xor, 6, 3, 4, 0);
		send_op(op_and, 7, 1, 3, 0);
		send_op(op_sub, 8, 2, 4, 0);
		drain_retires();
		report_test("independent ops", e0);
	endtask

	task automatic dependency_chains();
		int e0;
		e0 = errors;
		apply_reset();
		send_op(op_addi, 1, 0, 0, rand_imm());
		send_op(op_add, 2, 1, 1, 0);
		send_op(op_sub, 3, 2, 1, 0);
		// r2 rewritten while older readers are in flight
		send_op(op_addi, 2, 2, 0, 16'h0007);
		send_op(op_xor, 4, 2, 3, 0);
		send_op(op_and, 5, 4, 1, 0);
		send_op(op_or, 6, 5, 2, 0);
		send_op(op_addi, 2, 0, 0, 16'h0001);
		send_op(op_add, 7, 2, 2, 0);
		drain_retires();
		report_test("dependency chains", e0);
	endtask

	task automatic branch_not_taken();
		int e0;
		e0 = errors;
		apply_reset();
		send_op(op_addi, 1, 0, 0, rand_imm());
		send_op(op_addi, 2, 1, 0, 16'h0001);
		send_op(op_beq, 0, 1, 2, 16'h0040);
		send_op(op_bne, 0, 1, 1, 16'h0040);
		send_op(op_add, 3, 1, 2, 0);
		drain_retires();
		report_test("branch not taken", e0);
	endtask

	task automatic branch_taken();
		int              e0;
		logic [XLEN-1:0] br_pc;
		e0 = errors;
		apply_reset();
		send_op(op_addi, 1, 0, 0, rand_imm());
		send_op(op_addi, 2, 0, 0, rand_imm());
		send_op(op_add, 3, 1, 2, 0);
		br_pc = pc_next;
		send_op(op_beq, 0, 3, 3, 16'hffe0);
		// wrong path
		send_op(op_addi, 1, 0, 0, 16'h0111);
		send_op(op_addi, 2, 0, 0, 16'h0222);
		send_op(op_add, 3, 1, 1, 0);
		wait_flush_done();
		pc_next = br_pc + 32'hffff_ffe0;
		send_op(op_add, 4, 1, 2, 0);
		send_op(op_xor, 5, 3, 1, 0);
		drain_retires();
		report_test("branch taken", e0);
	endtask

	task automatic retire_burst();
		int      e0;
		opcode_e ops [6];
		e0  = errors;
		ops = '{op_addi, op_add, op_sub, op_xor, op_and, op_or};
		apply_reset();
		// each op reads the previous result, so the queue and ROB back up
		for (int i = 0; i < 30; i++)
			send_op(ops[i % 6], 1 + i % 7, (i == 0) ? 0 : 1 + (i - 1) % 7, (i * 5) % 8,
				rand_imm());
		drain_retires();
		checks++;
		assert (stalls > 0) else begin
			$display("ERROR: fetch_ready never dropped during the burst");
			errors++;
		end
		report_test("burst", e0);
	endtask

	task automatic illegal_opcode();
		int e0;
		e0 = errors;
		apply_reset();
		send_op(op_addi, 1, 0, 0, rand_imm());
		send_op(opcode_e'(4'h9), 0, 0, 0, 0);
		drive_idle();
		while (!exc_seen)
			@(negedge clk);
		repeat (20) begin
			@(negedge clk);
			fetch_pkt        = '0;
			fetch_pkt.valid  = 1'b1;
			fetch_pkt.opcode = op_addi;
			#1;
			checks++;
			assert (!fetch_ready) else begin
				$display("FAIL %0t: fetch_ready high after the exception", $time);
				errors++;
			end
		end
		drain_retires();
		report_test("illegal opcode", e0);
	endtask

	initial begin
		int unused_seed;
		clk         = 1'b0;
		rst_n       = 1'b0;
		fetch_pkt   = '0;
		errors      = 0;
		checks      = 0;
		stalls      = 0;
		cycles      = 0;
		squashing   = 1'b0;
		exc_seen    = 1'b0;
		pc_next     = '0;
		unused_seed = $urandom(83);
		independent_ops();
		dependency_chains();
		branch_not_taken();
		branch_taken();
		retire_burst();
		illegal_opcode();
		errors += i_backend.i_backend_assertions.fail_count;
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- backend.f
verilog/backend_pkg.sv
verilog/backend_ctrl.sv
verilog/rename_unit.sv
verilog/issue_queue.sv
verilog/prf.sv
verilog/exec_unit.sv
verilog/rob.sv
verilog/backend.sv
sim/backend_assertions.sv
sim/tb_backend.sv
